// ==== fetch_mux.f ====
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/mux_group_if.sv
hdl/line_aligner.sv
hdl/slot_builder.sv
hdl/mux_stage_reg.sv
hdl/flow_detect.sv
hdl/fetch_mux_top.sv
verification/fetch_mux_checker.sv
verification/fetch_mux_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_mux

sources:
  # Packages first, then the interface and the RTL
  - hdl/isa_pkg.sv
  - hdl/fetch_pkg.sv
  - hdl/mux_group_if.sv
  - hdl/line_aligner.sv
  - hdl/slot_builder.sv
  - hdl/mux_stage_reg.sv
  - hdl/flow_detect.sv
  - hdl/fetch_mux_top.sv

  - target: simulation
    files:
      - verification/fetch_mux_checker.sv
      - verification/fetch_mux_tb.sv

// ==== verification/fetch_mux_tb.sv ====
// Testbench for the fetch multiplexer stage
// Applies a table of fetch groups and checks slots, masks and flow outputs
`timescale 1ns/100ps
`default_nettype none

module fetch_mux_tb;

	import isa_pkg::*;
	import fetch_pkg::*;

	localparam int NS = NUM_SLOTS_DEF;
	localparam int LW = LINE_W_DEF;
	localparam int PW = PC_W_DEF;
	localparam int LINE_WORDS = LW / INSN_W;
	localparam int NUM_LINES = 4;
	localparam int NUM_ROWS = 17;
	localparam int RESET_CYCLES = 8;

	// Four cycles per row is well above what any row needs, stall rows included
	localparam int CYCLE_LIMIT = 4 * NUM_ROWS + RESET_CYCLES + 50;

	// Row flag bits
	localparam logic [5:0] F_SSM = 6'h01;
	localparam logic [5:0] F_NMI = 6'h02;
	localparam logic [5:0] F_IRQ = 6'h04;
	localparam logic [5:0] F_STOMP = 6'h08;
	localparam logic [5:0] F_MISS = 6'h10;
	localparam logic [5:0] F_STALL = 6'h20;

	// Fetch PCs, each one at the start of a line
	localparam logic [31:0] PC_B = 32'h0001_0000;
	localparam logic [31:0] PC_C = 32'h0001_0040;
	localparam logic [31:0] PC_D = 32'h0002_0000;
	localparam logic [31:0] PC_E = 32'h0003_0000;

	logic clk;
	logic rst_i;
	logic en_i;
	logic stall_i;
	logic advance_i;
	logic [LW-1:0] cline_i;
	logic [PW-1:0] pc_i;
	logic ssm_i;
	logic nmi_i;
	logic irq_i;
	logic stomp_i;
	logic branchmiss_i;
	logic [PW-1:0] misspc_i;
	logic [NS*INSN_W-1:0] slot_ins_o;
	logic [NS*PW-1:0] slot_pc_o;
	logic [NS-1:0] slot_valid_o;
	logic [NS-1:0] slot_ssm_o;
	logic do_branch_o;
	logic do_call_o;
	logic do_ret_o;
	logic [PW-1:0] branch_tgt_o;
	logic [PW-1:0] ret_pc_o;

	// Cache lines, filler words plus a few flow instructions
	logic [31:0] line_words [NUM_LINES][LINE_WORDS];

	// Stimulus and expected values, one entry per row
	// Expected word index per slot is a nibble with slot 0 lowest, 8 means NOP
	int row_line [NUM_ROWS];
	logic [31:0] row_pc [NUM_ROWS];
	logic [5:0] row_flags [NUM_ROWS];
	logic [31:0] row_miss [NUM_ROWS];
	logic [15:0] row_idx [NUM_ROWS];
	logic [3:0] row_valid [NUM_ROWS];
	logic [3:0] row_ssm [NUM_ROWS];
	logic [2:0] row_do [NUM_ROWS];
	logic [31:0] row_tgt [NUM_ROWS];
	logic [31:0] row_ret [NUM_ROWS];

	logic [31:0] lfsr_state;
	int cycle_cnt = 0;
	int row_errs;
	int tests_run;
	int tests_failed;

	fetch_mux_top #(
		.NUM_SLOTS(NS),
		.LINE_W(LW),
		.PC_W(PW)
	) fetch_mux_top_i (
		.clk(clk),
		.rst_i(rst_i),
		.en_i(en_i),
		.stall_i(stall_i),
		.advance_i(advance_i),
		.cline_i(cline_i),
		.pc_i(pc_i),
		.ssm_i(ssm_i),
		.nmi_i(nmi_i),
		.irq_i(irq_i),
		.stomp_i(stomp_i),
		.branchmiss_i(branchmiss_i),
		.misspc_i(misspc_i),
		.slot_ins_o(slot_ins_o),
		.slot_pc_o(slot_pc_o),
		.slot_valid_o(slot_valid_o),
		.slot_ssm_o(slot_ssm_o),
		.do_branch_o(do_branch_o),
		.do_call_o(do_call_o),
		.do_ret_o(do_ret_o),
		.branch_tgt_o(branch_tgt_o),
		.ret_pc_o(ret_pc_o)
	);

	// ==============================
	// Clock and run limit
	// ==============================

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ==============================
	// Stimulus helpers
	// ==============================

	// Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Displacement counts words and fills bits 31..7
	function automatic logic [31:0] branch_word(input logic [6:0] op, input int disp);
		return {disp[24:0], op};
	endfunction

	task automatic build_lines();
		logic [31:0] v;
		for (int l = 0; l < NUM_LINES; l++) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				draw_bits(25, v);
				line_words[l][w] = {v[24:0], OP_ALU};
			end
		end
		// Call at word 2 shadows the return right behind it
		line_words[1][2] = branch_word(OP_BSR, 5);
		line_words[1][3] = {25'd0, OP_RET};
		// Return first, so the branch after it never counts
		line_words[2][0] = {25'd0, OP_RET};
		line_words[2][1] = branch_word(OP_BRA, 3);
		// Forward branch in word 0 and a backward one in word 3
		line_words[3][0] = branch_word(OP_BRA, 8);
		line_words[3][3] = branch_word(OP_BRA, -2);
	endtask

	task automatic set_row(input int r, input int line, input logic [31:0] pc,
		input logic [5:0] flags, input logic [31:0] miss, input logic [15:0] idx,
		input logic [3:0] valid, input logic [3:0] ssm, input logic [2:0] dos,
		input logic [31:0] tgt, input logic [31:0] ret);
		row_line[r] = line;
		row_pc[r] = pc;
		row_flags[r] = flags;
		row_miss[r] = miss;
		row_idx[r] = idx;
		row_valid[r] = valid;
		row_ssm[r] = ssm;
		row_do[r] = dos;
		row_tgt[r] = tgt;
		row_ret[r] = ret;
	endtask

	// Expected flow flags are {ret, call, branch}
	task automatic fill_table();
		// Alignment at word offsets 0, 3, 5 and 7
		set_row(0, 0, PC_B, 0, 0, 16'h3210, 4'hF, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(1, 0, PC_B + 12, 0, 0, 16'h6543, 4'hF, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(2, 0, PC_B + 20, 0, 0, 16'h8765, 4'hF, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(3, 0, PC_B + 28, 0, 0, 16'h8887, 4'hF, 4'h0, 3'b000, RESET_PC, RESET_PC);
		// Flow priority
		set_row(4, 1, PC_C, 0, 0, 16'h3210, 4'hF, 4'h0, 3'b011, PC_C + 28, PC_C + 12);
		set_row(5, 2, PC_D, 0, 0, 16'h3210, 4'hF, 4'h0, 3'b100, RESET_PC, RESET_PC);
		// Interrupts, stomp and branch miss
		set_row(6, 3, PC_E, F_IRQ, 0, 16'h3210, 4'h0, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(7, 1, PC_C, F_NMI, 0, 16'h3210, 4'h0, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(8, 2, PC_D, F_STOMP, 0, 16'h3210, 4'h0, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(9, 3, PC_E, F_MISS, PC_E + 8, 16'h3210, 4'hC, 4'h0, 3'b001, PC_E + 4,
			RESET_PC);
		// Single step, then stepping off again
		set_row(10, 0, PC_B, F_SSM, 0, 16'h8880, 4'h1, 4'hE, 3'b000, RESET_PC, RESET_PC);
		set_row(11, 1, PC_C, F_SSM, 0, 16'h8888, 4'h0, 4'hF, 3'b000, RESET_PC, RESET_PC);
		set_row(12, 0, PC_B + 12, 0, 0, 16'h6543, 4'hF, 4'h0, 3'b000, RESET_PC, RESET_PC);
		// Repeated group, then a stall that must hold it
		set_row(13, 3, PC_E, 0, 0, 16'h3210, 4'hF, 4'h0, 3'b001, PC_E + 32, RESET_PC);
		set_row(14, 3, PC_E, 0, 0, 16'h8888, 4'hF, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(15, 1, PC_C, F_STALL, 0, 16'h8888, 4'hF, 4'h0, 3'b000, RESET_PC, RESET_PC);
		set_row(16, 2, PC_D, 0, 0, 16'h3210, 4'hF, 4'h0, 3'b100, RESET_PC, RESET_PC);
	endtask

	task automatic drive_row(input int r);
		for (int w = 0; w < LINE_WORDS; w++)
			cline_i[32*w +: 32] = line_words[row_line[r]][w];
		pc_i = row_pc[r];
		ssm_i = row_flags[r][0];
		nmi_i = row_flags[r][1];
		irq_i = row_flags[r][2];
		stomp_i = row_flags[r][3];
		branchmiss_i = row_flags[r][4];
		stall_i = row_flags[r][5];
		misspc_i = row_miss[r];
		en_i = 1'b1;
		advance_i = 1'b1;
	endtask

	// ==============================
	// Checks
	// ==============================

	task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("Error: %s expected %h got %h", sig, exp, got);
			row_errs++;
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (row_errs == 0) begin
			$display("Test %0d (%s) passed", tests_run, name);
		end else begin
			$display("Test %0d (%s) failed with %0d mismatches", tests_run, name, row_errs);
			tests_failed++;
		end
	endtask

	task automatic check_reset();
		row_errs = 0;
		for (int k = 0; k < NS; k++)
			check_value($sformatf("slot_ins_o[%0d]", k), NOP_WORD, slot_ins_o[32*k +: 32]);
		check_value("slot_valid_o", 32'h0, 32'(slot_valid_o));
		check_value("slot_ssm_o", 32'h0, 32'(slot_ssm_o));
		check_value("{do_ret_o, do_call_o, do_branch_o}", 32'h0,
			32'({do_ret_o, do_call_o, do_branch_o}));
		report_test("reset state");
	endtask

	task automatic check_row(input int r);
		int src;
		logic [3:0] idx;
		logic [31:0] exp_word;
		// A stalled row must still show the group of the row before it
		src = row_flags[r][5] ? r - 1 : r;
		row_errs = 0;
		for (int k = 0; k < NS; k++) begin
			idx = row_idx[r][4*k +: 4];
			exp_word = (idx > 7) ? NOP_WORD : line_words[row_line[src]][idx];
			check_value($sformatf("slot_ins_o[%0d]", k), exp_word, slot_ins_o[32*k +: 32]);
			check_value($sformatf("slot_pc_o[%0d]", k), row_pc[src] + 32'(4 * k),
				slot_pc_o[32*k +: 32]);
		end
		check_value("slot_valid_o", 32'(row_valid[r]), 32'(slot_valid_o));
		check_value("slot_ssm_o", 32'(row_ssm[r]), 32'(slot_ssm_o));
		check_value("do_branch_o", 32'(row_do[r][0]), 32'(do_branch_o));
		check_value("do_call_o", 32'(row_do[r][1]), 32'(do_call_o));
		check_value("do_ret_o", 32'(row_do[r][2]), 32'(do_ret_o));
		check_value("branch_tgt_o", row_tgt[r], branch_tgt_o);
		check_value("ret_pc_o", row_ret[r], ret_pc_o);
		report_test($sformatf("row %0d, pc %h", r, row_pc[r]));
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		rst_i = 1'b1;
		en_i = 1'b0;
		stall_i = 1'b0;
		advance_i = 1'b0;
		cline_i = '0;
		pc_i = '0;
		ssm_i = 1'b0;
		nmi_i = 1'b0;
		irq_i = 1'b0;
		stomp_i = 1'b0;
		branchmiss_i = 1'b0;
		misspc_i = '0;
		lfsr_state = 32'h1c54;
		tests_run = 0;
		tests_failed = 0;
		build_lines();
		fill_table();

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_i = 1'b0;
		check_reset();

		for (int r = 0; r < NUM_ROWS; r++) begin
			drive_row(r);
			@(posedge clk);
			#1;
			advance_i = 1'b0;
			// Keep the stall up for two more enabled edges
			if (row_flags[r][5]) begin
				repeat (2) @(posedge clk);
				#1;
			end
			check_row(r);
		end
		en_i = 1'b0;
		stall_i = 1'b0;

		$display("%0d tests run, %0d failed", tests_run, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/fetch_mux_checker.sv ====
// Bound assertions on the fetch multiplexer outputs
// Flow flag consistency, step masking and quiet outputs after reset
`timescale 1ns/100ps
`default_nettype none

module fetch_mux_checker #(
	parameter int NUM_SLOTS = fetch_pkg::NUM_SLOTS_DEF
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic en_i,
	input wire logic stall_i,
	input wire logic [NUM_SLOTS-1:0] slot_valid_i,
	input wire logic [NUM_SLOTS-1:0] slot_ssm_i,
	input wire logic do_branch_i,
	input wire logic do_call_i,
	input wire logic do_ret_i
);

	// Set once the stage has taken its first group after reset
	logic loaded;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			loaded <= 1'b0;
		end else if (en_i && !stall_i) begin
			loaded <= 1'b1;
		end
	end

	// ==============================
	// Flow flags
	// ==============================

	// A call is always a branch as well
	a_call_is_branch: assert property (@(posedge clk) disable iff (rst_i)
		do_call_i |-> do_branch_i)
		else $error("do_call_i high without do_branch_i");

	// Only one flow change can win the scan
	a_branch_or_ret: assert property (@(posedge clk) disable iff (rst_i)
		!(do_branch_i && do_ret_i))
		else $error("do_branch_i and do_ret_i high together");

	// Stepping leaves at most slot 0 valid
	a_step_slot0: assert property (@(posedge clk) disable iff (rst_i)
		(|slot_ssm_i) |-> (slot_valid_i[NUM_SLOTS-1:1] == '0))
		else $error("valid slot above slot 0 while stepping");

	// The reset group holds NOPs only
	a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst_i)
		!loaded |-> !(do_branch_i || do_call_i || do_ret_i))
		else $error("flow output high before the first enabled edge");

endmodule

bind fetch_mux_top fetch_mux_checker #(.NUM_SLOTS(NUM_SLOTS)) u_fetch_mux_checker (
	.clk(clk),
	.rst_i(rst_i),
	.en_i(en_i),
	.stall_i(stall_i),
	.slot_valid_i(slot_valid_o),
	.slot_ssm_i(slot_ssm_o),
	.do_branch_i(do_branch_o),
	.do_call_i(do_call_o),
	.do_ret_i(do_ret_o)
);

`default_nettype wire

// ==== hdl/fetch_mux_top.sv ====
// Fetch multiplexer stage of a superscalar front end
// Aligns a cache line into slots, gates them, registers them and finds flow changes
`timescale 1ns/100ps
`default_nettype none

module fetch_mux_top #(
	parameter int NUM_SLOTS = fetch_pkg::NUM_SLOTS_DEF,
	parameter int LINE_W = fetch_pkg::LINE_W_DEF,
	parameter int PC_W = fetch_pkg::PC_W_DEF
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic en_i,
	input wire logic stall_i,
	input wire logic advance_i,
	input wire logic [LINE_W-1:0] cline_i,
	input wire logic [PC_W-1:0] pc_i,
	input wire logic ssm_i,
	input wire logic nmi_i,
	input wire logic irq_i,
	input wire logic stomp_i,
	input wire logic branchmiss_i,
	input wire logic [PC_W-1:0] misspc_i,
	output logic [NUM_SLOTS*isa_pkg::INSN_W-1:0] slot_ins_o,
	output logic [NUM_SLOTS*PC_W-1:0] slot_pc_o,
	output logic [NUM_SLOTS-1:0] slot_valid_o,
	output logic [NUM_SLOTS-1:0] slot_ssm_o,
	output logic do_branch_o,
	output logic do_call_o,
	output logic do_ret_o,
	output logic [PC_W-1:0] branch_tgt_o,
	output logic [PC_W-1:0] ret_pc_o
);

	import isa_pkg::*;

	logic stage_en;
	logic [NUM_SLOTS-1:0][INSN_W-1:0] aligned;
	logic redundant;

	// Group leaving the gating logic, and group held in the stage
	mux_group_if #(.NUM_SLOTS(NUM_SLOTS), .PC_W(PC_W)) built_grp ();
	mux_group_if #(.NUM_SLOTS(NUM_SLOTS), .PC_W(PC_W)) stage_grp ();

	// A stall overrides the enable and freezes the stage
	assign stage_en = en_i & ~stall_i;

	// ==============================
	// Front half, combinational
	// ==============================

	line_aligner #(
		.NUM_SLOTS(NUM_SLOTS),
		.LINE_W(LINE_W),
		.PC_W(PC_W)
	) u_line_aligner (
		.clk(clk),
		.rst_i(rst_i),
		.advance_i(advance_i),
		.cline_i(cline_i),
		.pc_i(pc_i),
		.aligned_o(aligned),
		.redundant_o(redundant)
	);

	slot_builder #(
		.NUM_SLOTS(NUM_SLOTS),
		.PC_W(PC_W)
	) u_slot_builder (
		.clk(clk),
		.rst_i(rst_i),
		.en_i(stage_en),
		.aligned_i(aligned),
		.redundant_i(redundant),
		.pc_i(pc_i),
		.ssm_i(ssm_i),
		.nmi_i(nmi_i),
		.irq_i(irq_i),
		.stomp_i(stomp_i),
		.branchmiss_i(branchmiss_i),
		.misspc_i(misspc_i),
		.grp_o(built_grp.src)
	);

	// ==============================
	// Stage register and flow decode
	// ==============================

	mux_stage_reg #(
		.NUM_SLOTS(NUM_SLOTS),
		.PC_W(PC_W)
	) u_mux_stage_reg (
		.clk(clk),
		.rst_i(rst_i),
		.en_i(stage_en),
		.grp_i(built_grp.dst),
		.grp_o(stage_grp.src)
	);

	flow_detect #(
		.NUM_SLOTS(NUM_SLOTS),
		.PC_W(PC_W)
	) u_flow_detect (
		.grp_i(stage_grp.dst),
		.do_branch_o(do_branch_o),
		.do_call_o(do_call_o),
		.do_ret_o(do_ret_o),
		.branch_tgt_o(branch_tgt_o),
		.ret_pc_o(ret_pc_o)
	);

	// Registered group flattened onto plain ports, slot 0 in the low bits
	assign slot_ins_o = stage_grp.ins;
	assign slot_pc_o = stage_grp.pc;
	assign slot_valid_o = stage_grp.valid;
	assign slot_ssm_o = stage_grp.ssm;

endmodule

`default_nettype wire

// ==== hdl/flow_detect.sv ====
// Flow change detector for the fetch multiplexer
// Finds the first valid branch, call or return and computes its target
`timescale 1ns/100ps
`default_nettype none

module flow_detect #(
	parameter int NUM_SLOTS = fetch_pkg::NUM_SLOTS_DEF,
	parameter int PC_W = fetch_pkg::PC_W_DEF
) (
	mux_group_if.dst grp_i,
	output logic do_branch_o,
	output logic do_call_o,
	output logic do_ret_o,
	output logic [PC_W-1:0] branch_tgt_o,
	output logic [PC_W-1:0] ret_pc_o
);

	import isa_pkg::*;
	import fetch_pkg::*;

	localparam logic [PC_W-1:0] NO_TGT = PC_W'(RESET_PC);

	insn_u dec [NUM_SLOTS];
	logic [NUM_SLOTS-1:0][PC_W-1:0] tgt;
	logic [NUM_SLOTS-1:0][PC_W-1:0] link;
	logic found;

	// ==============================
	// Per-slot decode
	// ==============================

	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			dec[k] = grp_i.ins[k];

			// Displacement is in words, so scale by four after sign extension
			tgt[k] = grp_i.pc[k] + (PC_W'($signed(dec[k].bra.disp)) << 2);

			// A call returns to the word after itself
			link[k] = grp_i.pc[k] + PC_W'(4);
		end
	end

	// ==============================
	// Priority scan
	// ==============================

	// Lowest valid slot wins, later flow changes are never reached
	always_comb begin
		found = 1'b0;
		do_branch_o = 1'b0;
		do_call_o = 1'b0;
		do_ret_o = 1'b0;
		branch_tgt_o = NO_TGT;
		ret_pc_o = NO_TGT;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			if (!found && grp_i.valid[k]) begin
				case (dec[k].alu.opcode)
					OP_BRA: begin
						found = 1'b1;
						do_branch_o = 1'b1;
						branch_tgt_o = tgt[k];
					end
					OP_BSR: begin
						// A call is a branch that also pushes the link PC
						found = 1'b1;
						do_branch_o = 1'b1;
						do_call_o = 1'b1;
						branch_tgt_o = tgt[k];
						ret_pc_o = link[k];
					end
					OP_RET: begin
						found = 1'b1;
						do_ret_o = 1'b1;
					end
					default: begin
						// Ordinary instructions do not change flow
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mux_stage_reg.sv ====
// Pipeline register of the fetch multiplexer
// Holds one gated instruction group and freezes it while the stage is stalled
`timescale 1ns/100ps
`default_nettype none

module mux_stage_reg #(
	parameter int NUM_SLOTS = fetch_pkg::NUM_SLOTS_DEF,
	parameter int PC_W = fetch_pkg::PC_W_DEF
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic en_i,
	mux_group_if.dst grp_i,
	mux_group_if.src grp_o
);

	import isa_pkg::*;

	// ==============================
	// Control bits
	// ==============================

	// Nothing leaves the stage as valid until a real group has been loaded
	always_ff @(posedge clk) begin
		if (rst_i) begin
			grp_o.valid <= '0;
			grp_o.ssm <= '0;
		end else if (en_i) begin
			grp_o.valid <= grp_i.valid;
			grp_o.ssm <= grp_i.ssm;
		end
	end

	// ==============================
	// Slot words and PCs
	// ==============================

	// Reset parks NOPs at PC zero so downstream decode sees harmless words
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int k = 0; k < NUM_SLOTS; k++) begin
				grp_o.ins[k] <= NOP_WORD;
				grp_o.pc[k] <= {PC_W{1'b0}};
			end
		end else if (en_i) begin
			// A low enable holds the whole group, which is the stall path
			grp_o.ins <= grp_i.ins;
			grp_o.pc <= grp_i.pc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/slot_builder.sv ====
// Slot builder for the fetch multiplexer
// Assigns slot PCs and applies repeat, single-step, interrupt and miss gating
`timescale 1ns/100ps
`default_nettype none

module slot_builder #(
	parameter int NUM_SLOTS = fetch_pkg::NUM_SLOTS_DEF,
	parameter int PC_W = fetch_pkg::PC_W_DEF
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic en_i,
	input wire logic [NUM_SLOTS-1:0][isa_pkg::INSN_W-1:0] aligned_i,
	input wire logic redundant_i,
	input wire logic [PC_W-1:0] pc_i,
	input wire logic ssm_i,
	input wire logic nmi_i,
	input wire logic irq_i,
	input wire logic stomp_i,
	input wire logic branchmiss_i,
	input wire logic [PC_W-1:0] misspc_i,
	mux_group_if.src grp_o
);

	import isa_pkg::*;

	logic prev_ssm;
	logic step_first;
	logic kill_all;
	logic [NUM_SLOTS-1:0] step_sup;
	logic [NUM_SLOTS-1:0] miss_sup;
	logic [NUM_SLOTS-1:0][PC_W-1:0] slot_pc;

	// Step flag as seen by the last group that entered the stage
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_ssm <= 1'b0;
		end else if (en_i) begin
			prev_ssm <= ssm_i;
		end
	end

	// Rising edge of the step flag lets exactly one instruction through
	assign step_first = ssm_i & ~prev_ssm;

	// Interrupts and stomps wipe out the whole group
	assign kill_all = nmi_i | irq_i | stomp_i;

	// ==============================
	// Per-slot gating
	// ==============================

	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			// Slots are consecutive words starting at the fetch PC
			slot_pc[k] = pc_i + PC_W'(4 * k);

			// While stepping, only slot 0 of the first stepped group survives
			step_sup[k] = ssm_i & ~(step_first & (k == 0));

			// Anything before the corrected PC was fetched down the wrong path
			miss_sup[k] = branchmiss_i & (misspc_i > slot_pc[k]);
		end
	end

	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			if (redundant_i || step_sup[k])
				grp_o.ins[k] = NOP_WORD;
			else
				grp_o.ins[k] = aligned_i[k];
		end
	end

	assign grp_o.pc = slot_pc;
	assign grp_o.ssm = step_sup;

	// A slot survives only if none of the suppress conditions hit it
	assign grp_o.valid = ~(step_sup | miss_sup | {NUM_SLOTS{kill_all}});

endmodule

`default_nettype wire

// ==== hdl/line_aligner.sv ====
// Line aligner for the fetch multiplexer
// Shifts the cache line so the fetch PC word lands in slot 0 and flags repeats
`timescale 1ns/100ps
`default_nettype none

module line_aligner #(
	parameter int NUM_SLOTS = fetch_pkg::NUM_SLOTS_DEF,
	parameter int LINE_W = fetch_pkg::LINE_W_DEF,
	parameter int PC_W = fetch_pkg::PC_W_DEF
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic advance_i,
	input wire logic [LINE_W-1:0] cline_i,
	input wire logic [PC_W-1:0] pc_i,
	output logic [NUM_SLOTS-1:0][isa_pkg::INSN_W-1:0] aligned_o,
	output logic redundant_o
);

	import isa_pkg::*;

	localparam int LINE_WORDS = LINE_W / INSN_W;
	localparam int IDX_W = $clog2(LINE_WORDS);

	// The line plus one group of NOPs, so a shift never runs off the end
	localparam int EXT_W = LINE_W + NUM_SLOTS * INSN_W;

	logic [IDX_W-1:0] word_idx;
	logic [EXT_W-1:0] ext_line;
	logic prev_vld;
	logic [PC_W-1:0] prev_pc;
	logic [NUM_SLOTS-1:0][INSN_W-1:0] prev_aligned;

	// ==============================
	// Alignment
	// ==============================

	// Word index inside the line, byte offset bits dropped
	assign word_idx = pc_i[IDX_W+1:2];

	// Words past the line end come from the NOP fill
	assign ext_line = {{NUM_SLOTS{NOP_WORD}}, cline_i} >> (word_idx * INSN_W);
	assign aligned_o = ext_line[NUM_SLOTS*INSN_W-1:0];

	// ==============================
	// Repeat detection
	// ==============================

	// Snapshot of the group taken at the last advance
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_vld <= 1'b0;
		end else if (advance_i) begin
			prev_vld <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_i) begin
			prev_pc <= pc_i;
			prev_aligned <= aligned_o;
		end
	end

	// Same PC and same words means the fetch unit handed us the group again
	assign redundant_o = prev_vld && (prev_pc == pc_i) && (prev_aligned == aligned_o);

endmodule

`default_nettype wire

// ==== hdl/mux_group_if.sv ====
// Instruction group carried between the stages of the fetch multiplexer
// One word, PC, valid bit and step-suppress bit per slot
`timescale 1ns/100ps
`default_nettype none

interface mux_group_if #(
	parameter int NUM_SLOTS = fetch_pkg::NUM_SLOTS_DEF,
	parameter int PC_W = fetch_pkg::PC_W_DEF
) ();

	import isa_pkg::*;

	// Slot 0 sits in the low word of each packed array
	logic [NUM_SLOTS-1:0][INSN_W-1:0] ins;
	logic [NUM_SLOTS-1:0][PC_W-1:0] pc;
	logic [NUM_SLOTS-1:0] valid;

	// Set on slots that single step turned into NOPs
	logic [NUM_SLOTS-1:0] ssm;

	// Producer side
	modport src (output ins, output pc, output valid, output ssm);

	// Consumer side
	modport dst (input ins, input pc, input valid, input ssm);

endinterface

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
// Default configuration of the fetch multiplexer stage
// Slot count, line and PC widths, and the fallback PC
`default_nettype none

package fetch_pkg;

	// Instructions handed on per cycle
	localparam int NUM_SLOTS_DEF = 4;

	// A cache line holds eight words
	localparam int LINE_W_DEF = 256;

	// Byte address width of a PC
	localparam int PC_W_DEF = 32;

	// Reported as target when the group holds no flow change
	localparam logic [31:0] RESET_PC = 32'hFFFC0000;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
// Instruction set definitions shared by the fetch multiplexer
// Word formats, opcodes and the two-way decoded instruction view
`default_nettype none

package isa_pkg;

	// ==============================
	// Word geometry
	// ==============================

	// Every instruction is one fixed-size word
	localparam int INSN_W = 32;
	localparam int OPC_W = 7;

	// Branch displacement fills everything above the opcode
	localparam int DISP_W = INSN_W - OPC_W;

	// ==============================
	// Opcodes
	// ==============================

	localparam logic [OPC_W-1:0] OP_NOP = 7'h0B;
	localparam logic [OPC_W-1:0] OP_ALU = 7'h0C;
	localparam logic [OPC_W-1:0] OP_BRA = 7'h20;
	localparam logic [OPC_W-1:0] OP_BSR = 7'h21;
	localparam logic [OPC_W-1:0] OP_RET = 7'h22;

	// A NOP with all operand fields zero
	localparam logic [INSN_W-1:0] NOP_WORD = {{(INSN_W-OPC_W){1'b0}}, OP_NOP};

	// ==============================
	// Decoded views
	// ==============================

	// Register format, fields listed from the top bit down
	typedef struct packed {
		logic [6:0] func;
		logic [5:0] rs2;
		logic [5:0] rs1;
		logic [5:0] rd;
		logic [OPC_W-1:0] opcode;
	} alu_insn_t;

	// Branch format, displacement counts words and not bytes
	typedef struct packed {
		logic [DISP_W-1:0] disp;
		logic [OPC_W-1:0] opcode;
	} bra_insn_t;

	// Both views share the opcode in the low bits
	typedef union packed {
		alu_insn_t alu;
		bra_insn_t bra;
	} insn_u;

endpackage

`default_nettype wire
